//--- list.f
+incdir+tb
rtl/cpu_pkg.sv
rtl/fetch_stage.sv
rtl/decoder.sv
rtl/reg_file.sv
rtl/hazard_unit.sv
rtl/execute_stage.sv
rtl/cpu_core.sv
tb/tb_cpu.sv

//--- tb/cpu_model.svh
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

// ********************
// program generator
// ********************

// test modes
localparam int M_RESET  = 0;
localparam int M_ALU    = 1;
localparam int M_FWD    = 2;
localparam int M_LOAD   = 3;
localparam int M_BRANCH = 4;
localparam int M_MIX    = 5;

// instruction groups
localparam int K_ALU  = 0;
localparam int K_FWD  = 1;
localparam int K_LOAD = 2;
localparam int K_STLD = 3;
localparam int K_BEQZ = 4;
localparam int K_B    = 5;

int gen_pc;
int gen_end;

function automatic int rnd(input int n);
    return $unsigned($random(seed)) % n;
endfunction

function automatic data_t ri_word(input opcode_e op, input reg_addr_t rx,
                                  input logic [7:0] imm8);
    return {op, rx, imm8};
endfunction

function automatic data_t rri_word(input opcode_e op, input reg_addr_t rx,
                                   input reg_addr_t ry, input logic [4:0] imm5);
    return {op, rx, ry, imm5};
endfunction

function automatic data_t rrr_word(input opcode_e op, input reg_addr_t rx,
                                   input reg_addr_t ry, input reg_addr_t rz,
                                   input logic [1:0] f2);
    return {op, rx, ry, rz, f2};
endfunction

// forward only, never past the final loop
function automatic int branch_ofs();
    int ofs;
    ofs = rnd(4);
    if (gen_pc + 1 + ofs > gen_end) begin
        ofs = gen_end - gen_pc - 1;
    end
    return (ofs < 0) ? 0 : ofs;
endfunction

task automatic emit(input data_t word);
    if (gen_pc < gen_end) begin
        imem[gen_pc] = word;
        gen_pc++;
    end
endtask

// one ALU op reading ra and rb, rd is the register it writes
task automatic add_alu_op(input reg_addr_t ra, input reg_addr_t rb, output reg_addr_t rd);
    int sel;
    sel = rnd(6);
    rd = ra;
    case (sel)
        0: emit(ri_word(OP_LI, ra, 8'(rnd(256))));
        1: emit(ri_word(OP_ADDIU, ra, 8'(rnd(256))));
        2, 3: begin
            rd = reg_addr_t'(rnd(8));
            emit(rrr_word(OP_RRR, ra, rb, rd, (sel == 2) ? 2'b01 : 2'b11));
        end
        4: emit(rrr_word(OP_LOGIC, ra, rb, 3'd0, 2'b00));
        default: emit(rrr_word(OP_LOGIC, ra, rb, 3'd0, 2'b01));
    endcase
endtask

task automatic add_store(input reg_addr_t rd);
    emit(rri_word(OP_SW, reg_addr_t'(rnd(8)), rd, 5'(rnd(32))));
endtask

task automatic build_program(input int mode, input int len);
    int         kind;
    reg_addr_t  rd;
    reg_addr_t  prev;
    reg_addr_t  prev2;
    reg_addr_t  base;
    logic [4:0] ofs;
    for (int i = 0; i < 64; i++) begin
        imem[i] = NOP_INST;
    end
    gen_pc  = 0;
    gen_end = len - 1;
    prev    = 3'd1;
    prev2   = 3'd2;
    while (mode != M_RESET && gen_pc < gen_end) begin
        case (mode)
            M_ALU:    kind = K_ALU;
            M_FWD:    kind = K_FWD;
            M_LOAD:   kind = K_LOAD + rnd(2);
            M_BRANCH: kind = (rnd(2) == 0) ? K_ALU : K_BEQZ + rnd(2);
            default:  kind = rnd(6);
        endcase
        case (kind)
            K_ALU: begin
                add_alu_op(reg_addr_t'(rnd(8)), reg_addr_t'(rnd(8)), rd);
                add_store(rd);
            end
            K_FWD: begin
                // sources written one and two instructions earlier
                add_alu_op(prev, prev2, rd);
                prev2 = prev;
                prev  = rd;
                if (rnd(2) == 0) begin
                    add_store(rd);
                end
            end
            K_LOAD: begin
                rd = reg_addr_t'(rnd(8));
                emit(rri_word(OP_LW, reg_addr_t'(rnd(8)), rd, 5'(rnd(32))));
                if (rnd(2) == 0) begin
                    add_alu_op(rd, reg_addr_t'(rnd(8)), rd);
                end
                add_store(rd);
            end
            K_STLD: begin
                // reload the word just stored
                base = reg_addr_t'(rnd(8));
                ofs  = 5'(rnd(32));
                rd   = reg_addr_t'(rnd(8));
                emit(rri_word(OP_SW, base, reg_addr_t'(rnd(8)), ofs));
                emit(rri_word(OP_LW, base, rd, ofs));
                add_store(rd);
            end
            K_BEQZ: begin
                rd = reg_addr_t'(rnd(8));
                if (rnd(2) == 0) begin
                    emit(ri_word(OP_LI, rd, 8'h00));
                end
                emit(ri_word(OP_BEQZ, rd, 8'(branch_ofs())));
                add_store(reg_addr_t'(rnd(8)));
            end
            default: begin
                emit({OP_B, 11'(branch_ofs())});
                add_store(reg_addr_t'(rnd(8)));
            end
        endcase
    end
    // final loop, B to itself
    imem[gen_end] = {OP_B, 11'h7ff};
endtask

// ********************
// reference model
// ********************
task automatic run_model();
    data_t regs_m [8];
    data_t mem_m [256];
    inst_u ins;
    data_t addr;
    int    pc;
    int    steps;
    logic  done;
    regs_m = '{default: '0};
    mem_m  = dmem;
    exp_addr.delete();
    exp_data.delete();
    pc    = 0;
    steps = 0;
    done  = 1'b0;
    while (!done && steps < 256) begin
        ins = imem[pc % 64];
        pc  = pc + 1;
        steps++;
        case (ins.jmp.opcode)
            OP_LI: regs_m[ins.ri.rx] = {8'h00, ins.ri.imm8};
            OP_ADDIU: begin
                regs_m[ins.ri.rx] = regs_m[ins.ri.rx] + {{8{ins.ri.imm8[7]}}, ins.ri.imm8};
            end
            OP_RRR: begin
                if (ins.rrr.funct2 == 2'b01) begin
                    regs_m[ins.rrr.rz] = regs_m[ins.rrr.rx] + regs_m[ins.rrr.ry];
                end else if (ins.rrr.funct2 == 2'b11) begin
                    regs_m[ins.rrr.rz] = regs_m[ins.rrr.rx] - regs_m[ins.rrr.ry];
                end
            end
            OP_LOGIC: begin
                if (ins.rrr.funct2 == 2'b00) begin
                    regs_m[ins.rrr.rx] = regs_m[ins.rrr.rx] & regs_m[ins.rrr.ry];
                end else if (ins.rrr.funct2 == 2'b01) begin
                    regs_m[ins.rrr.rx] = regs_m[ins.rrr.rx] | regs_m[ins.rrr.ry];
                end
            end
            OP_LW: begin
                addr = regs_m[ins.rri.rx] + {{11{ins.rri.imm5[4]}}, ins.rri.imm5};
                regs_m[ins.rri.ry] = mem_m[addr[7:0]];
            end
            OP_SW: begin
                addr = regs_m[ins.rri.rx] + {{11{ins.rri.imm5[4]}}, ins.rri.imm5};
                mem_m[addr[7:0]] = regs_m[ins.rri.ry];
                exp_addr.push_back(addr);
                exp_data.push_back(regs_m[ins.rri.ry]);
            end
            OP_B: begin
                if (ins.jmp.imm11 == 11'h7ff) begin
                    done = 1'b1;
                end else begin
                    pc = pc + $signed(ins.jmp.imm11);
                end
            end
            OP_BEQZ: begin
                if (regs_m[ins.ri.rx] == '0) begin
                    pc = pc + $signed(ins.ri.imm8);
                end
            end
            default: ;
        endcase
    end
endtask

`endif

//--- tb/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu import cpu_pkg::*; ();

    localparam int     NUM_TESTS   = 9;
    localparam int     PROG_LEN    = 40;
    // visits to the final loop before a test ends
    localparam int     IDLE_VISITS = 8;
    localparam longint WATCHDOG_NS = longint'(NUM_TESTS) * (4 * PROG_LEN + 100) * 20;

    logic  clk_50MHz;
    logic  rst;
    pc_t   imem_addr;
    data_t imem_data;
    data_t dmem_addr;
    data_t dmem_wdata;
    data_t dmem_rdata;
    logic  dmem_we;
    logic  dmem_re;

    data_t  imem [64];
    data_t  dmem [256];
    integer seed;
    data_t  exp_addr [$];
    data_t  exp_data [$];
    int     test_errs;
    int     stores_seen;
    int     pass_cnt;
    int     fail_cnt;

    `include "cpu_model.svh"

    cpu_core DUT (
        .clk_50MHz    (clk_50MHz),
        .rst          (rst),
        .imem_addr_o  (imem_addr),
        .imem_data_i  (imem_data),
        .dmem_addr_o  (dmem_addr),
        .dmem_wdata_o (dmem_wdata),
        .dmem_we_o    (dmem_we),
        .dmem_re_o    (dmem_re),
        .dmem_rdata_i (dmem_rdata)
    );

    initial clk_50MHz = 1'b0;
    always #10 clk_50MHz = ~clk_50MHz;

    // ********************
    // memories
    // ********************
    assign imem_data  = imem[imem_addr[5:0]];
    assign dmem_rdata = dmem[dmem_addr[7:0]];

    always @(posedge clk_50MHz) begin
        if (dmem_we) begin
            dmem[dmem_addr[7:0]] <= dmem_wdata;
        end
    end

    function automatic string mode_name(input int mode);
        case (mode)
            M_RESET:  return "reset";
            M_ALU:    return "alu";
            M_FWD:    return "forward";
            M_LOAD:   return "load";
            M_BRANCH: return "branch";
            default:  return "mix";
        endcase
    endfunction

    task automatic compare_value(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            $display("MISMATCH time %0t signal %s expected %h actual %h",
                     $time, name, expected, actual);
            test_errs++;
        end
    endtask

    task automatic check_reset_state();
        compare_value("imem_addr_o", '0, imem_addr);
        compare_value("dmem_we_o", '0, data_t'(dmem_we));
        compare_value("dmem_re_o", '0, data_t'(dmem_re));
    endtask

    task automatic check_store();
        data_t want_addr;
        data_t want_data;
        stores_seen++;
        if (exp_addr.size() == 0) begin
            $display("%0t: unexpected store to %h with data %h", $time, dmem_addr, dmem_wdata);
            test_errs++;
        end else begin
            want_addr = exp_addr.pop_front();
            want_data = exp_data.pop_front();
            compare_value("dmem_addr_o", want_addr, dmem_addr);
            compare_value("dmem_wdata_o", want_data, dmem_wdata);
        end
    endtask

    // bus is stable mid-cycle
    always @(negedge clk_50MHz) begin
        if (rst && dmem_we) begin
            check_store();
        end
    end

    // ********************
    // test sequencing
    // ********************
    task automatic run_test(input int mode);
        int visits;
        int len;
        len = (mode == M_RESET) ? 1 : PROG_LEN;
        @(posedge clk_50MHz);
        rst <= 1'b0;
        @(negedge clk_50MHz);
        test_errs   = 0;
        stores_seen = 0;
        build_program(mode, len);
        for (int i = 0; i < 256; i++) begin
            dmem[i] = $random(seed);
        end
        run_model();
        check_reset_state();
        repeat (3) begin
            @(negedge clk_50MHz);
            check_reset_state();
        end
        @(posedge clk_50MHz);
        rst <= 1'b1;
        // first cycle out of reset, pc not yet advanced
        @(negedge clk_50MHz);
        check_reset_state();
        visits = 0;
        while (visits < IDLE_VISITS) begin
            @(negedge clk_50MHz);
            if (imem_addr == pc_t'(len - 1)) begin
                visits++;
            end
        end
        @(posedge clk_50MHz);
        if (exp_addr.size() != 0) begin
            $display("%0t: %0d expected stores never appeared", $time, exp_addr.size());
            test_errs++;
        end
        if (test_errs == 0) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
        end
        $display("test %-7s %s: %0d stores, %0d errors", mode_name(mode),
                 (test_errs == 0) ? "ok" : "bad", stores_seen, test_errs);
    endtask

    initial begin
        seed        = 32'hffd2c026;
        rst         = 1'b0;
        pass_cnt    = 0;
        fail_cnt    = 0;
        test_errs   = 0;
        stores_seen = 0;
        for (int i = 0; i < 64; i++) begin
            imem[i] = NOP_INST;
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] = data_t'(i * 16'h0101);
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test((t < M_MIX) ? t : M_MIX);
        end
        $display("summary: %0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core import cpu_pkg::*; (
    input  logic  clk_50MHz,
    input  logic  rst,
    output pc_t   imem_addr_o,
    input  data_t imem_data_i,
    output data_t dmem_addr_o,
    output data_t dmem_wdata_o,
    output logic  dmem_we_o,
    output logic  dmem_re_o,
    input  data_t dmem_rdata_i
);

    if_id_t    if_id;
    id_ex_t    id_ex_d;
    id_ex_t    id_ex_q;
    ex_mem_t   ex_mem_q;
    mem_wb_t   mem_wb_q;
    ctrl_t     dec_ctrl;
    data_t     dec_imm;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    data_t     rs1_data;
    data_t     rs2_data;
    logic      stall;
    fwd_sel_e  fwd_a;
    fwd_sel_e  fwd_b;
    data_t     alu_res;
    data_t     store_data;
    logic      branch_taken;
    pc_t       branch_target;

    // ********************
    // fetch and decode
    // ********************
    fetch_stage u_fetch (
        .clk_50MHz_i     (clk_50MHz),
        .rst             (rst),
        .stall_i         (stall),
        .flush_i         (branch_taken),
        .branch_target_i (branch_target),
        .imem_data_i     (imem_data_i),
        .imem_addr_o     (imem_addr_o),
        .if_id_o         (if_id)
    );

    decoder u_decoder (
        .if_id_i    (if_id),
        .ctrl_o     (dec_ctrl),
        .imm_o      (dec_imm),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr)
    );

    reg_file u_regs (
        .clk_50MHz  (clk_50MHz),
        .rst        (rst),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .wb_i       (mem_wb_q),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    hazard_unit u_hazard (
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .id_ex_i    (id_ex_q),
        .ex_mem_i   (ex_mem_q),
        .mem_wb_i   (mem_wb_q),
        .stall_o    (stall),
        .fwd_a_o    (fwd_a),
        .fwd_b_o    (fwd_b)
    );

    assign id_ex_d = '{ctrl: dec_ctrl, pc_next: if_id.pc_next,
                       rs1_addr: rs1_addr, rs2_addr: rs2_addr,
                       rs1_data: rs1_data, rs2_data: rs2_data, imm: dec_imm};

    // bubble on load-use stall or on a taken branch
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            id_ex_q <= '0;
        end else if (stall || branch_taken) begin
            id_ex_q <= '0;
        end else begin
            id_ex_q <= id_ex_d;
        end
    end

    // ********************
    // execute
    // ********************
    execute_stage u_execute (
        .id_ex_i         (id_ex_q),
        .fwd_a_i         (fwd_a),
        .fwd_b_i         (fwd_b),
        .ex_mem_fwd_i    (ex_mem_q.alu_res),
        .mem_wb_fwd_i    (mem_wb_q.wb_data),
        .alu_res_o       (alu_res),
        .store_data_o    (store_data),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target)
    );

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            ex_mem_q <= '0;
        end else begin
            ex_mem_q <= '{reg_we: id_ex_q.ctrl.reg_we, mem_re: id_ex_q.ctrl.mem_re,
                          mem_we: id_ex_q.ctrl.mem_we, wb_addr: id_ex_q.ctrl.wb_addr,
                          alu_res: alu_res, store_data: store_data};
        end
    end

    // ********************
    // memory and writeback
    // ********************
    assign dmem_addr_o  = ex_mem_q.alu_res;
    assign dmem_wdata_o = ex_mem_q.store_data;
    assign dmem_we_o    = ex_mem_q.mem_we;
    assign dmem_re_o    = ex_mem_q.mem_re;

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            mem_wb_q <= '0;
        end else begin
            mem_wb_q.reg_we  <= ex_mem_q.reg_we;
            mem_wb_q.wb_addr <= ex_mem_q.wb_addr;
            mem_wb_q.wb_data <= ex_mem_q.mem_re ? dmem_rdata_i : ex_mem_q.alu_res;
        end
    end

    a_mem_excl: assert property (@(posedge clk_50MHz) disable iff (!rst)
        !(dmem_we_o && dmem_re_o));

    // flushed slot in execute is a bubble, so no load can stall decode
    a_no_stall_after_flush: assert property (@(posedge clk_50MHz) disable iff (!rst)
        branch_taken |=> !stall);

endmodule

`default_nettype wire

//--- rtl/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage import cpu_pkg::*; (
    input  id_ex_t   id_ex_i,
    input  fwd_sel_e fwd_a_i,
    input  fwd_sel_e fwd_b_i,
    input  data_t    ex_mem_fwd_i,
    input  data_t    mem_wb_fwd_i,
    output data_t    alu_res_o,
    output data_t    store_data_o,
    output logic     branch_taken_o,
    output pc_t      branch_target_o
);

    data_t rs1_val;
    data_t rs2_val;
    data_t op_a;
    data_t op_b;

    function automatic data_t fwd_mux(input fwd_sel_e sel, input data_t reg_val,
                                      input data_t mem_val, input data_t wb_val);
        data_t val;
        unique case (sel)
            FWD_MEM: val = mem_val;
            FWD_WB:  val = wb_val;
            default: val = reg_val;
        endcase
        return val;
    endfunction

    assign rs1_val = fwd_mux(fwd_a_i, id_ex_i.rs1_data, ex_mem_fwd_i, mem_wb_fwd_i);
    assign rs2_val = fwd_mux(fwd_b_i, id_ex_i.rs2_data, ex_mem_fwd_i, mem_wb_fwd_i);

    assign op_a = id_ex_i.ctrl.zero_a ? '0 : rs1_val;
    assign op_b = id_ex_i.ctrl.use_imm ? id_ex_i.imm : rs2_val;

    // ********************
    // ALU
    // ********************
    always_comb begin
        unique case (id_ex_i.ctrl.alu_op)
            ALU_ADD: alu_res_o = op_a + op_b;
            ALU_SUB: alu_res_o = op_a - op_b;
            ALU_AND: alu_res_o = op_a & op_b;
            ALU_OR:  alu_res_o = op_a | op_b;
            default: alu_res_o = '0;
        endcase
    end

    // SW stores ry
    assign store_data_o = rs2_val;

    // offset is relative to the address after the branch
    assign branch_taken_o  = id_ex_i.ctrl.is_branch ||
                             (id_ex_i.ctrl.is_beqz && rs1_val == '0);
    assign branch_target_o = id_ex_i.pc_next + id_ex_i.imm;

endmodule

`default_nettype wire

//--- rtl/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import cpu_pkg::*; (
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    input  id_ex_t    id_ex_i,
    input  ex_mem_t   ex_mem_i,
    input  mem_wb_t   mem_wb_i,
    output logic      stall_o,
    output fwd_sel_e  fwd_a_o,
    output fwd_sel_e  fwd_b_o
);

    // ********************
    // load-use
    // ********************
    assign stall_o = id_ex_i.ctrl.mem_re &&
                     (id_ex_i.ctrl.wb_addr == rs1_addr_i ||
                      id_ex_i.ctrl.wb_addr == rs2_addr_i);

    // ********************
    // forwarding
    // ********************
    function automatic fwd_sel_e pick_src(input reg_addr_t src, input ex_mem_t ex_mem,
                                          input mem_wb_t mem_wb);
        fwd_sel_e sel;
        sel = FWD_NONE;
        // younger result wins
        if (ex_mem.reg_we && ex_mem.wb_addr == src) begin
            sel = FWD_MEM;
        end else if (mem_wb.reg_we && mem_wb.wb_addr == src) begin
            sel = FWD_WB;
        end
        return sel;
    endfunction

    assign fwd_a_o = pick_src(id_ex_i.rs1_addr, ex_mem_i, mem_wb_i);
    assign fwd_b_o = pick_src(id_ex_i.rs2_addr, ex_mem_i, mem_wb_i);

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import cpu_pkg::*; (
    input  logic      clk_50MHz,
    input  logic      rst,
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    input  mem_wb_t   wb_i,
    output data_t     rs1_data_o,
    output data_t     rs2_data_o
);

    data_t regs [NUM_REGS];

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            regs <= '{default: '0};
        end else if (wb_i.reg_we) begin
            regs[wb_i.wb_addr] <= wb_i.wb_data;
        end
    end

    // write-through so decode sees a same-cycle writeback
    assign rs1_data_o = (wb_i.reg_we && wb_i.wb_addr == rs1_addr_i) ?
                        wb_i.wb_data : regs[rs1_addr_i];
    assign rs2_data_o = (wb_i.reg_we && wb_i.wb_addr == rs2_addr_i) ?
                        wb_i.wb_data : regs[rs2_addr_i];

endmodule

`default_nettype wire

//--- rtl/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder import cpu_pkg::*; (
    input  if_id_t    if_id_i,
    output ctrl_t     ctrl_o,
    output data_t     imm_o,
    output reg_addr_t rs1_addr_o,
    output reg_addr_t rs2_addr_o
);

    inst_u inst;

    assign inst = if_id_i.inst;

    // rx and ry sit in the same bits in every format
    assign rs1_addr_o = inst.rri.rx;
    assign rs2_addr_o = inst.rri.ry;

    always_comb begin
        ctrl_o = '0;
        imm_o  = '0;
        unique case (inst.jmp.opcode)
            OP_B: begin
                ctrl_o.is_branch = 1'b1;
                imm_o = {{5{inst.jmp.imm11[10]}}, inst.jmp.imm11};
            end
            OP_BEQZ: begin
                ctrl_o.is_beqz = 1'b1;
                imm_o = {{8{inst.ri.imm8[7]}}, inst.ri.imm8};
            end
            OP_ADDIU: begin
                ctrl_o.use_imm = 1'b1;
                ctrl_o.reg_we  = 1'b1;
                ctrl_o.wb_addr = inst.ri.rx;
                imm_o = {{8{inst.ri.imm8[7]}}, inst.ri.imm8};
            end
            OP_LI: begin
                // 0 + zero-extended imm8
                ctrl_o.use_imm = 1'b1;
                ctrl_o.zero_a  = 1'b1;
                ctrl_o.reg_we  = 1'b1;
                ctrl_o.wb_addr = inst.ri.rx;
                imm_o = {8'h00, inst.ri.imm8};
            end
            OP_LW: begin
                ctrl_o.use_imm = 1'b1;
                ctrl_o.reg_we  = 1'b1;
                ctrl_o.mem_re  = 1'b1;
                ctrl_o.wb_addr = inst.rri.ry;
                imm_o = {{11{inst.rri.imm5[4]}}, inst.rri.imm5};
            end
            OP_SW: begin
                ctrl_o.use_imm = 1'b1;
                ctrl_o.mem_we  = 1'b1;
                imm_o = {{11{inst.rri.imm5[4]}}, inst.rri.imm5};
            end
            OP_RRR: begin
                ctrl_o.wb_addr = inst.rrr.rz;
                ctrl_o.reg_we  = inst.rrr.funct2[0];
                ctrl_o.alu_op  = inst.rrr.funct2[1] ? ALU_SUB : ALU_ADD;
            end
            OP_LOGIC: begin
                ctrl_o.wb_addr = inst.rrr.rx;
                ctrl_o.reg_we  = !inst.rrr.funct2[1];
                ctrl_o.alu_op  = inst.rrr.funct2[0] ? ALU_OR : ALU_AND;
            end
            default: begin
                // NOP and anything unknown
                ctrl_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import cpu_pkg::*; (
    input  logic   clk_50MHz_i,
    input  logic   rst,
    input  logic   stall_i,
    input  logic   flush_i,
    input  pc_t    branch_target_i,
    input  data_t  imem_data_i,
    output pc_t    imem_addr_o,
    output if_id_t if_id_o
);

    pc_t pc_q;
    pc_t pc_plus1;

    assign pc_plus1    = pc_q + 1'b1;
    assign imem_addr_o = pc_q;

    // flush wins over stall
    always_ff @(posedge clk_50MHz_i or negedge rst) begin
        if (!rst) begin
            pc_q <= '0;
        end else if (flush_i) begin
            pc_q <= branch_target_i;
        end else if (!stall_i) begin
            pc_q <= pc_plus1;
        end
    end

    always_ff @(posedge clk_50MHz_i or negedge rst) begin
        if (!rst) begin
            if_id_o <= '{inst: NOP_INST, pc_next: '0};
        end else if (flush_i) begin
            // fetched word is on the wrong path
            if_id_o <= '{inst: NOP_INST, pc_next: '0};
        end else if (!stall_i) begin
            if_id_o <= '{inst: imem_data_i, pc_next: pc_plus1};
        end
    end

    // a stall never meets a flush, so the pc always holds
    a_pc_hold: assert property (@(posedge clk_50MHz_i) disable iff (!rst)
        stall_i |=> imem_addr_o == $past(imem_addr_o));

endmodule

`default_nettype wire

//--- rtl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // ********************
    // widths
    // ********************
    localparam int DATA_W     = 16;
    localparam int REG_ADDR_W = 3;
    localparam int NUM_REGS   = 8;
    localparam int PC_W       = 16;

    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [PC_W-1:0]       pc_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [4:0] {
        OP_NOP   = 5'b00001,
        OP_B     = 5'b00010,
        OP_BEQZ  = 5'b00100,
        OP_ADDIU = 5'b01001,
        OP_LI    = 5'b01101,
        OP_LW    = 5'b10011,
        OP_SW    = 5'b11011,
        OP_RRR   = 5'b11100,
        OP_LOGIC = 5'b11101
    } opcode_e;

    // NOP word, opcode in the top five bits
    localparam data_t NOP_INST = 16'h0800;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    // ********************
    // instruction formats
    // ********************
    typedef union packed {
        struct packed {
            opcode_e   opcode;
            reg_addr_t rx;
            reg_addr_t ry;
            reg_addr_t rz;
            logic [1:0] funct2;
        } rrr;
        struct packed {
            opcode_e    opcode;
            reg_addr_t  rx;
            logic [7:0] imm8;
        } ri;
        struct packed {
            opcode_e    opcode;
            reg_addr_t  rx;
            reg_addr_t  ry;
            logic [4:0] imm5;
        } rri;
        struct packed {
            opcode_e     opcode;
            logic [10:0] imm11;
        } jmp;
    } inst_u;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      use_imm;
        // forces operand A to zero, LI only
        logic      zero_a;
        logic      reg_we;
        reg_addr_t wb_addr;
        logic      mem_re;
        logic      mem_we;
        logic      is_branch;
        logic      is_beqz;
    } ctrl_t;

    // ********************
    // pipeline registers
    // ********************
    typedef struct packed {
        inst_u inst;
        pc_t   pc_next;
    } if_id_t;

    typedef struct packed {
        ctrl_t     ctrl;
        pc_t       pc_next;
        reg_addr_t rs1_addr;
        reg_addr_t rs2_addr;
        data_t     rs1_data;
        data_t     rs2_data;
        data_t     imm;
    } id_ex_t;

    typedef struct packed {
        logic      reg_we;
        logic      mem_re;
        logic      mem_we;
        reg_addr_t wb_addr;
        data_t     alu_res;
        data_t     store_data;
    } ex_mem_t;

    typedef struct packed {
        logic      reg_we;
        reg_addr_t wb_addr;
        data_t     wb_data;
    } mem_wb_t;

endpackage

`default_nettype wire
